/* control_unit.f */
rv_isa_pkg.sv
ctrl_pkg.sv
instr_classifier.sv
alu_op_decoder.sv
control_fsm.sv
control_unit.sv
tb_clock_gen.sv
control_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= control_unit_tb
FILELIST  ?= control_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "Simulation gave no result"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* control_unit_tb.sv */
`timescale 1ns/1ns

module control_unit_tb
    import rv_isa_pkg::*, ctrl_pkg::*;
();

    localparam int DRIVE_DELAY      = 1;
    localparam int MAX_INSTR_CYCLES = 12;
    // Reset, R ops, addi/lui, slt/slti, jalr, branches, ld, sd, illegal
    localparam int TEST_CYCLES      = 13 + 15 + 10 + 20 + 5 + 16 + 7 + 5 + 4;
    localparam int TIMEOUT_CYCLES   = 2 * TEST_CYCLES;
    localparam logic [6:0] F7_SUB   = 7'b0100000;
    localparam logic [6:0] OPC_JAL  = 7'b1101111;    // Not decoded

    logic   CLK;
    logic   RST;
    instr_u instr;
    logic   alu_zero;
    logic   alu_less;
    ctrl_t  ctrl;

    ctrl_t  trace[$];                // One control word per cycle of the last instruction
    string  test_name;
    int     test_errors;
    int     error_count;
    int     tests_run;
    int     tests_bad;
    int     cycle_count;

    tb_clock_gen clock_gen (
        .CLK (CLK),
        .RST (RST)
    );

    control_unit dut (
        .CLK      (CLK),
        .RST      (RST),
        .instr    (instr),
        .alu_zero (alu_zero),
        .alu_less (alu_less),
        .ctrl     (ctrl)
    );

    function automatic logic [7:0] strobe_bits(input ctrl_t c);
        return {c.pc_we, c.ir_load, c.alu_out_we, c.reg_ab_we,
                c.rf_we, c.mem_reg_we, c.mem_we, c.dp_rst};
    endfunction

    function automatic instr_u r_word(input logic [6:0] f7, input logic [2:0] f3);
        instr_u w;
        w          = instr_u'($urandom());   // Random register fields
        w.r.opcode = OPC_OP;
        w.r.funct3 = f3;
        w.r.funct7 = f7;
        return w;
    endfunction

    function automatic instr_u i_word(input logic [6:0] opc, input logic [2:0] f3);
        instr_u w;
        w          = instr_u'($urandom());   // Random registers and immediate
        w.i.opcode = opc;
        w.i.funct3 = f3;
        return w;
    endfunction

    task automatic tick();
        @(posedge CLK);
        #DRIVE_DELAY;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got == exp) else begin
            $display("ERR t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_bad++;
        end
        $display("%-16s %s (%0d errors)", test_name, (test_errors == 0) ? "ok" : "FAIL",
                 test_errors);
    endtask

    // Entered 1 ns after the edge into FETCH, leaves at the same point of the next FETCH
    task automatic run_instr(input instr_u word, input logic zero, input logic less,
                             input int exp_cycles);
        int n;
        n        = 0;
        instr    = word;
        alu_zero = zero;
        alu_less = less;
        trace.delete();
        do begin
            @(negedge CLK);
            trace.push_back(ctrl);
            n++;
            tick();
        end while (!ctrl.ir_load && n < MAX_INSTR_CYCLES);
        assert (ctrl.ir_load) else begin
            $display("t=%0t %s: no instruction fetch within %0d cycles", $time, test_name, n);
            test_errors++;
            error_count++;
        end
        check_val("fetch interval", 32'(n), 32'(exp_cycles));
        check_val("mux_a in FETCH", 32'(trace[0].mux_a), 32'(MUXA_PC));
        check_val("mux_b in FETCH", 32'(trace[0].mux_b), 32'(MUXB_FOUR));
        check_val("reg_ab_we in DECODE", 32'(trace[1].reg_ab_we), 32'd1);
    endtask

    task automatic alu_op_in_execute(input alu_op_e op);
        check_val("alu_op in EXECUTE", 32'(trace[2].alu_op), 32'(op));
    endtask

    task automatic operands_in_execute(input mux_a_e a, input mux_b_e b);
        check_val("mux_a in EXECUTE", 32'(trace[2].mux_a), 32'(a));
        check_val("mux_b in EXECUTE", 32'(trace[2].mux_b), 32'(b));
    endtask

    task automatic reg_write_step(input data_sel_e sel);
        check_val("rf_we in write step", 32'(trace[3].rf_we), 32'd1);
        check_val("data_sel in write step", 32'(trace[3].data_sel), 32'(sel));
    endtask

    task automatic count_writes(output int rf_n, output int mem_n, output int mreg_n);
        rf_n   = 0;
        mem_n  = 0;
        mreg_n = 0;
        foreach (trace[k]) begin
            rf_n   += int'(trace[k].rf_we);
            mem_n  += int'(trace[k].mem_we);
            mreg_n += int'(trace[k].mem_reg_we);
        end
    endtask

    task automatic reset_sequence();
        start_test("reset");
        @(negedge CLK);
        check_val("strobes in reset", 32'(strobe_bits(ctrl)), 32'h01);
        @(negedge RST);
        @(negedge CLK);                      // First cycle after release
        check_val("strobes after reset", 32'(strobe_bits(ctrl)), 32'h01);
        tick();
        @(negedge CLK);
        check_val("strobes in WAIT", 32'(strobe_bits(ctrl)), 32'h00);
        tick();
        check_val("ir_load", 32'(ctrl.ir_load), 32'd1);
        finish_test();
    endtask

    task automatic r_type_ops();
        start_test("add sub and");
        run_instr(r_word(F7_BASE, F3_ADD), 1'b0, 1'b0, 5);
        alu_op_in_execute(ALU_ADD);
        operands_in_execute(MUXA_REG_A, MUXB_REG_B);
        reg_write_step(DSEL_ALU_OUT);
        run_instr(r_word(F7_SUB, F3_ADD), 1'b0, 1'b0, 5);
        alu_op_in_execute(ALU_SUB);
        reg_write_step(DSEL_ALU_OUT);
        run_instr(r_word(F7_BASE, F3_AND), 1'b0, 1'b0, 5);
        alu_op_in_execute(ALU_AND);
        reg_write_step(DSEL_ALU_OUT);
        finish_test();
    endtask

    task automatic imm_ops();
        start_test("addi lui");
        run_instr(i_word(OPC_OP_IMM, F3_ADD), 1'b0, 1'b0, 5);
        alu_op_in_execute(ALU_ADD);
        operands_in_execute(MUXA_REG_A, MUXB_IMM);
        reg_write_step(DSEL_ALU_OUT);
        run_instr(i_word(OPC_LUI, 3'($urandom())), 1'b0, 1'b0, 5);
        operands_in_execute(MUXA_ZERO_UPPER, MUXB_IMM);
        reg_write_step(DSEL_ALU_OUT);
        finish_test();
    endtask

    task automatic set_less_than();
        start_test("slt slti");
        for (int less = 1; less >= 0; less--) begin
            run_instr(r_word(F7_BASE, F3_SLT), 1'b0, less[0], 5);
            alu_op_in_execute(ALU_SLT);
            reg_write_step(less[0] ? DSEL_ONE : DSEL_ZERO);
            run_instr(i_word(OPC_OP_IMM, F3_SLT), 1'b0, less[0], 5);
            alu_op_in_execute(ALU_SLT);
            reg_write_step(less[0] ? DSEL_ONE : DSEL_ZERO);
        end
        finish_test();
    endtask

    task automatic jalr_link();
        start_test("jalr");
        run_instr(i_word(OPC_JALR, F3_ADD), 1'b0, 1'b0, 5);
        reg_write_step(DSEL_PC);
        check_val("pc_we in write step", 32'(trace[3].pc_we), 32'd1);
        finish_test();
    endtask

    task automatic branch_case(input logic [2:0] f3, input logic zero, input logic taken);
        run_instr(i_word(OPC_BRANCH, f3), zero, 1'b0, 4);
        check_val("pc_we in EXECUTE", 32'(trace[2].pc_we), 32'(taken));
        check_val("pc_from_alu in EXECUTE", 32'(trace[2].pc_from_alu), 32'(taken));
    endtask

    task automatic branches();
        start_test("beq bne");
        branch_case(F3_BEQ, 1'b1, 1'b1);
        branch_case(F3_BEQ, 1'b0, 1'b0);
        branch_case(F3_BNE, 1'b0, 1'b1);
        branch_case(F3_BNE, 1'b1, 1'b0);
        finish_test();
    endtask

    task automatic memory_ops();
        int rf_n;
        int mem_n;
        int mreg_n;
        start_test("ld sd");
        run_instr(i_word(OPC_LOAD, F3_LD), 1'b0, 1'b0, 7);
        check_val("mem_reg_we in READ_MEM", 32'(trace[4].mem_reg_we), 32'd1);
        check_val("rf_we in SAVE_REG", 32'(trace[5].rf_we), 32'd1);
        check_val("data_sel in SAVE_REG", 32'(trace[5].data_sel), 32'(DSEL_MEM_REG));
        run_instr(i_word(OPC_STORE, F3_SD), 1'b0, 1'b0, 5);
        count_writes(rf_n, mem_n, mreg_n);
        check_val("mem_we pulses for sd", 32'(mem_n), 32'd1);
        check_val("rf_we pulses for sd", 32'(rf_n), 32'd0);
        finish_test();
    endtask

    task automatic illegal_opcode();
        int rf_n;
        int mem_n;
        int mreg_n;
        start_test("illegal");
        run_instr(i_word(OPC_JAL, 3'($urandom())), 1'b0, 1'b0, 4);
        count_writes(rf_n, mem_n, mreg_n);
        check_val("write pulses", 32'(rf_n + mem_n + mreg_n), 32'd0);
        check_val("strobes in EXECUTE", 32'(strobe_bits(trace[2])), 32'h00);
        check_val("strobes in WAIT", 32'(strobe_bits(trace[3])), 32'h00);
        finish_test();
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("Timeout: run still going after %0d clock cycles", cycle_count);
        $display("Test failed");
        $finish;
    end

    initial begin
        instr       = '0;
        alu_zero    = 1'b0;
        alu_less    = 1'b0;
        error_count = 0;
        tests_run   = 0;
        tests_bad   = 0;
        void'($urandom(32'hf31e_297c));
        reset_sequence();
        r_type_ops();
        imm_ops();
        set_less_than();
        jalr_link();
        branches();
        memory_ops();
        illegal_opcode();
        $display("Tests run %0d, tests with errors %0d, failed checks %0d",
                 tests_run, tests_bad, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic CLK,
    output logic RST
);

    localparam int HALF_PERIOD = 4;          // 8 ns clock
    localparam int RST_CYCLES  = 10;

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    // Release just after a rising edge, like the other inputs
    initial begin
        RST = 1'b1;
        repeat (RST_CYCLES) @(posedge CLK);
        #1 RST = 1'b0;
    end

endmodule

/* control_unit.sv */
`timescale 1ns/1ns

module control_unit
    import rv_isa_pkg::*, ctrl_pkg::*;
(
    input  logic   CLK,
    input  logic   RST,
    input  instr_u instr,
    input  logic   alu_zero,
    input  logic   alu_less,
    output ctrl_t  ctrl
);

    instr_class_e instr_class;
    exec_t        exec;

    instr_classifier u_classifier (
        .instr       (instr),
        .instr_class (instr_class)
    );

    alu_op_decoder u_decoder (
        .instr       (instr),
        .instr_class (instr_class),
        .alu_less    (alu_less),
        .exec        (exec)
    );

    control_fsm u_fsm (
        .CLK         (CLK),
        .RST         (RST),
        .instr_class (instr_class),
        .exec        (exec),
        .alu_zero    (alu_zero),
        .ctrl        (ctrl)
    );

endmodule

/* control_fsm.sv */
`timescale 1ns/1ns

module control_fsm
    import ctrl_pkg::*;
(
    input  logic         CLK,
    input  logic         RST,
    input  instr_class_e instr_class,
    input  exec_t        exec,
    input  logic         alu_zero,
    output ctrl_t        ctrl
);

    state_e state;
    state_e state_next;
    logic   branch_taken;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state <= ST_RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            ST_RESET: begin
                state_next = ST_WAIT;
            end
            ST_WAIT: begin
                state_next = ST_FETCH;
            end
            ST_FETCH: begin
                state_next = ST_DECODE;
            end
            ST_DECODE: begin
                state_next = ST_EXECUTE;
            end
            ST_EXECUTE: begin
                state_next = exec.next;
            end
            ST_WAIT2: begin
                state_next = ST_READ_MEM;
            end
            ST_READ_MEM: begin
                state_next = ST_SAVE_REG;
            end
            default: begin
                state_next = ST_WAIT;           // All write steps end here
            end
        endcase
    end

    // beq takes the branch on zero, bne on nonzero
    assign branch_taken = alu_zero ^ exec.br_ne;

    always_comb begin
        ctrl = '0;
        case (state)
            ST_RESET: begin
                ctrl.dp_rst = 1'b1;
            end
            ST_FETCH: begin
                ctrl.ir_load = 1'b1;
                ctrl.pc_we   = 1'b1;            // PC + 4
                ctrl.alu_op  = ALU_ADD;
                ctrl.mux_a   = MUXA_PC;
                ctrl.mux_b   = MUXB_FOUR;
            end
            ST_DECODE: begin
                ctrl.reg_ab_we  = 1'b1;
                ctrl.alu_out_we = 1'b1;         // Branch target ahead of time
                ctrl.alu_op     = ALU_ADD;
                ctrl.mux_a      = MUXA_PC;
                ctrl.mux_b      = MUXB_IMM_SHIFTED;
            end
            ST_EXECUTE: begin
                ctrl.alu_op = exec.alu_op;
                ctrl.mux_a  = exec.mux_a;
                ctrl.mux_b  = exec.mux_b;
                if (instr_class == CLS_SB) begin
                    ctrl.pc_we       = branch_taken;
                    ctrl.pc_from_alu = branch_taken;
                end else begin
                    ctrl.alu_out_we = (exec.alu_op != ALU_NOP);
                end
            end
            ST_WRITE_ALU: begin
                ctrl.rf_we    = 1'b1;
                ctrl.data_sel = DSEL_ALU_OUT;
            end
            ST_SET_ONE: begin
                ctrl.rf_we    = 1'b1;
                ctrl.data_sel = DSEL_ONE;
            end
            ST_SET_ZERO: begin
                ctrl.rf_we    = 1'b1;
                ctrl.data_sel = DSEL_ZERO;
            end
            ST_JALR_WB: begin
                ctrl.rf_we       = 1'b1;        // rd gets the return address
                ctrl.data_sel    = DSEL_PC;
                ctrl.pc_we       = 1'b1;
                ctrl.pc_from_alu = 1'b1;
            end
            ST_WRITE_MEM: begin
                ctrl.mem_we = 1'b1;
            end
            ST_READ_MEM: begin
                ctrl.mem_reg_we = 1'b1;
            end
            ST_SAVE_REG: begin
                ctrl.rf_we    = 1'b1;
                ctrl.data_sel = DSEL_MEM_REG;
            end
            default: begin
                ctrl.alu_op = ALU_NOP;          // WAIT and WAIT2 idle
            end
        endcase
    end

    a_rf_mem_excl: assert property (
        @(posedge CLK) disable iff (RST)
        !(ctrl.rf_we && ctrl.mem_we)
    ) else $error("rf_we and mem_we high together");

    // Operands are latched in the cycle right after the fetch
    a_fetch_then_decode: assert property (
        @(posedge CLK) disable iff (RST)
        ctrl.ir_load |=> ctrl.reg_ab_we
    ) else $error("ir_load not followed by reg_ab_we");

    a_state_range: assert property (
        @(posedge CLK) disable iff (RST)
        state <= ST_SAVE_REG
    ) else $error("state out of range");

endmodule

/* alu_op_decoder.sv */
`timescale 1ns/1ns

module alu_op_decoder
    import rv_isa_pkg::*, ctrl_pkg::*;
(
    input  instr_u       instr,
    input  instr_class_e instr_class,
    input  logic         alu_less,
    output exec_t        exec
);

    state_e slt_next;

    assign slt_next = alu_less ? ST_SET_ONE : ST_SET_ZERO;

    always_comb begin
        exec = '{alu_op: ALU_NOP, mux_a: MUXA_REG_A, mux_b: MUXB_REG_B,
                 br_ne: 1'b0, next: ST_WAIT};
        case (instr_class)
            CLS_R: begin
                if (instr.r.funct7 != F7_BASE) begin
                    exec.alu_op = ALU_SUB;
                    exec.next   = ST_WRITE_ALU;
                end else if (instr.r.funct3 == F3_ADD) begin
                    exec.alu_op = ALU_ADD;
                    exec.next   = ST_WRITE_ALU;
                end else if (instr.r.funct3 == F3_AND) begin
                    exec.alu_op = ALU_AND;
                    exec.next   = ST_WRITE_ALU;
                end else if (instr.r.funct3 == F3_SLT) begin
                    exec.alu_op = ALU_SLT;
                    exec.next   = slt_next;
                end
            end
            CLS_I: begin
                exec.mux_b = MUXB_IMM;
                if (instr.i.opcode == OPC_JALR) begin
                    exec.alu_op = ALU_ADD;
                    exec.mux_b  = MUXB_IMM_EXT;
                    exec.next   = ST_JALR_WB;
                end else if (instr.i.opcode == OPC_OP_IMM && instr.i.funct3 == F3_ADD) begin
                    exec.alu_op = ALU_ADD;
                    exec.next   = ST_WRITE_ALU;
                end else if (instr.i.opcode == OPC_OP_IMM && instr.i.funct3 == F3_SLT) begin
                    exec.alu_op = ALU_SLT;
                    exec.next   = slt_next;
                end else if (instr.i.opcode == OPC_LOAD && instr.i.funct3 == F3_LD) begin
                    exec.alu_op = ALU_ADD;           // Address rs1 + imm
                    exec.next   = ST_WAIT2;
                end
            end
            CLS_S: begin
                if (instr.i.funct3 == F3_SD) begin
                    exec.alu_op = ALU_ADD;
                    exec.mux_b  = MUXB_IMM;
                    exec.next   = ST_WRITE_MEM;
                end
            end
            CLS_SB: begin
                exec.alu_op = ALU_SUB;               // Compare through zero flag
                exec.br_ne  = (instr.i.funct3 == F3_BNE);
            end
            CLS_U: begin
                exec.alu_op = ALU_ADD;
                exec.mux_a  = MUXA_ZERO_UPPER;
                exec.mux_b  = MUXB_IMM;
                exec.next   = ST_WRITE_ALU;
            end
            default: begin
                exec.alu_op = ALU_NOP;
            end
        endcase
    end

endmodule

/* instr_classifier.sv */
`timescale 1ns/1ns

module instr_classifier
    import rv_isa_pkg::*, ctrl_pkg::*;
(
    input  instr_u       instr,
    output instr_class_e instr_class
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr.i.opcode;
    assign funct3 = instr.i.funct3;

    always_comb begin
        case (opcode)
            OPC_OP: begin
                instr_class = CLS_R;
            end
            OPC_OP_IMM,
            OPC_LOAD,
            OPC_SYSTEM: begin
                instr_class = CLS_I;
            end
            OPC_STORE: begin
                instr_class = CLS_S;
            end
            OPC_BRANCH: begin
                instr_class = CLS_SB;
            end
            OPC_JALR: begin
                // funct3 001 under this opcode behaves as bne
                if (funct3 == F3_BNE) begin
                    instr_class = CLS_SB;
                end else begin
                    instr_class = CLS_I;
                end
            end
            OPC_LUI: begin
                instr_class = CLS_U;
            end
            default: begin
                instr_class = CLS_ILLEGAL;
            end
        endcase
    end

endmodule

/* ctrl_pkg.sv */
package ctrl_pkg;

    typedef enum logic [2:0] {
        CLS_R,
        CLS_I,
        CLS_S,
        CLS_SB,
        CLS_U,
        CLS_ILLEGAL
    } instr_class_e;

    typedef enum logic [2:0] {
        ALU_NOP = 3'b000,
        ALU_ADD = 3'b001,
        ALU_SUB = 3'b010,
        ALU_AND = 3'b011,
        ALU_SLT = 3'b110
    } alu_op_e;

    typedef enum logic [1:0] {
        MUXA_PC         = 2'b00,
        MUXA_REG_A      = 2'b01,
        MUXA_ZERO_UPPER = 2'b11          // Constant zero for lui
    } mux_a_e;

    typedef enum logic [2:0] {
        MUXB_REG_B       = 3'b000,
        MUXB_FOUR        = 3'b001,
        MUXB_IMM         = 3'b010,
        MUXB_IMM_SHIFTED = 3'b011,       // Branch offset, shifted left by one
        MUXB_IMM_EXT     = 3'b100
    } mux_b_e;

    typedef enum logic [2:0] {
        DSEL_ALU_OUT = 3'b000,
        DSEL_MEM_REG = 3'b001,
        DSEL_ONE     = 3'b010,
        DSEL_ZERO    = 3'b011,
        DSEL_PC      = 3'b100
    } data_sel_e;

    typedef enum logic [4:0] {
        ST_RESET,
        ST_WAIT,
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_WRITE_ALU,
        ST_SET_ONE,
        ST_SET_ZERO,
        ST_JALR_WB,
        ST_WRITE_MEM,
        ST_WAIT2,
        ST_READ_MEM,
        ST_SAVE_REG
    } state_e;

    typedef struct packed {
        alu_op_e   alu_op;
        mux_a_e    mux_a;
        mux_b_e    mux_b;
        data_sel_e data_sel;
        logic      pc_from_alu;          // PC takes ALU_OUT instead of ALU result
        logic      pc_we;
        logic      ir_load;
        logic      alu_out_we;
        logic      reg_ab_we;
        logic      rf_we;
        logic      mem_reg_we;
        logic      mem_we;
        logic      dp_rst;
    } ctrl_t;

    // Execute step as chosen by the decoder
    typedef struct packed {
        alu_op_e alu_op;
        mux_a_e  mux_a;
        mux_b_e  mux_b;
        logic    br_ne;                  // Branch on zero clear
        state_e  next;
    } exec_t;

endpackage

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    parameter int XLEN = 64;                 // Register and data width
    parameter int ILEN = 32;                 // Instruction width

    // Major opcodes of the supported subset
    parameter logic [6:0] OPC_OP     = 7'b0110011;
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
    parameter logic [6:0] OPC_LOAD   = 7'b0000011;
    parameter logic [6:0] OPC_SYSTEM = 7'b1110011;
    parameter logic [6:0] OPC_STORE  = 7'b0100011;
    parameter logic [6:0] OPC_BRANCH = 7'b1100011;
    parameter logic [6:0] OPC_JALR   = 7'b1100111;
    parameter logic [6:0] OPC_LUI    = 7'b0110111;

    parameter logic [2:0] F3_ADD = 3'b000;   // Also addi and jalr
    parameter logic [2:0] F3_AND = 3'b111;
    parameter logic [2:0] F3_SLT = 3'b010;   // Also slti
    parameter logic [2:0] F3_LD  = 3'b011;
    parameter logic [2:0] F3_SD  = 3'b011;
    parameter logic [2:0] F3_BEQ = 3'b000;
    parameter logic [2:0] F3_BNE = 3'b001;

    parameter logic [6:0] F7_BASE = 7'b0000000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Same 32-bit word, read either way by the decoder
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage
